/* Makefile */
TOP = tb_pool_top

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* sources.f */
+incdir+verilog
verilog/pool_pkg.sv
verilog/pool_if.sv
verilog/pool_ctrl.sv
verilog/map_fetch.sv
verilog/nbr_gather.sv
verilog/max_reduce.sv
verilog/pool_top.sv
testbench/tb_pool_top.sv

/* testbench/tb_pool_top.sv */
// Testbench for pool_top: LFSR stimulus, in-order memory models,
// reference model of the max pooling and checks
`include "pool_macros.svh"

module tb_pool_top;
    import pool_pkg::*;

    localparam int NUM_JOBS = 3;
    localparam int WAIT_MAX = 20000;

    logic clk;
    logic rst_n;
    logic cfg_vld, cfg_rdy;
    idx_t cfg_nip, cfg_map_base, cfg_ofm_rd_base, cfg_ofm_wr_base;
    k_cnt_t cfg_k;
    grp_cnt_t cfg_n_grp;
    idx_t map_rd_addr, ofm_rd_addr, ofm_wr_addr;
    logic map_rd_addr_vld, map_rd_addr_rdy, map_rd_dat_vld, map_rd_dat_rdy;
    logic ofm_rd_addr_vld, ofm_rd_addr_rdy, ofm_rd_dat_vld, ofm_rd_dat_rdy;
    logic ofm_wr_vld, ofm_wr_rdy;
    sram_word_t map_rd_dat;
    lane_vec_t ofm_rd_dat, ofm_wr_dat;

    // Memory contents and in-flight returns
    sram_word_t map_mem [0:65535];
    lane_vec_t  feat_mem [0:65535];
    sram_word_t map_pend [$];
    lane_vec_t  feat_pend [$];
    logic       map_taken, feat_taken;

    // Expected traffic from the reference model
    idx_t      exp_map_addr [$];
    idx_t      exp_rd_addr [$];
    idx_t      exp_wr_addr [$];
    lane_vec_t exp_wr_dat [$];

    logic [15:0] lfsr;
    int          err_cnt, chk_cnt, wr_cnt;
    logic        timed_out;
    int          j_nip, j_k, j_ng;
    idx_t        j_map, j_rd, j_wr;

    pool_top dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Galois LFSR with taps 0xB400 and one step per bit taken
    function automatic int rand_bits(int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
        chk_cnt++;
        assert (exp == act) else begin
            err_cnt++;
            $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_cond(logic ok, string what);
        chk_cnt++;
        assert (ok) else begin
            err_cnt++;
            $display("ERROR: %s", what);
        end
    endtask

    task automatic check_idle(string when);
        check_val({when, " cfg_rdy"}, 64'd1, 64'(cfg_rdy));
        check_val({when, " map_rd_addr_vld"}, 64'd0, 64'(map_rd_addr_vld));
        check_val({when, " map_rd_dat_rdy"}, 64'd0, 64'(map_rd_dat_rdy));
        check_val({when, " ofm_rd_addr_vld"}, 64'd0, 64'(ofm_rd_addr_vld));
        check_val({when, " ofm_wr_vld"}, 64'd0, 64'(ofm_wr_vld));
    endtask

    // ==============================
    // Reference model
    // ==============================
    function automatic void build_job();
        idx_t      slot [`POOL_MAP_SLOTS];
        idx_t      ma;
        idx_t      fa;
        lane_vec_t f;
        lane_vec_t mx;
        j_nip = rand_bits(3) % 6 + 1;
        j_k   = rand_bits(3) + 1;
        j_ng  = rand_bits(2) % 3 + 1;
        j_map = idx_t'(rand_bits(16));
        j_rd  = idx_t'(rand_bits(16));
        j_wr  = idx_t'(rand_bits(16));
        // Features for every index below 64 in every group
        for (int i = 0; i < 64 * j_ng; i++) begin
            feat_mem[j_rd + idx_t'(i)] = lane_vec_t'(rand_bits(32));
        end
        for (int p = 0; p < j_nip; p++) begin
            for (int s = 0; s < `POOL_MAP_SLOTS; s++) begin
                slot[s] = idx_t'(rand_bits(6));
            end
            ma = j_map + idx_t'(2 * p);
            map_mem[ma]             = {slot[3], slot[2], slot[1], slot[0]};
            map_mem[ma + idx_t'(1)] = {slot[7], slot[6], slot[5], slot[4]};
            exp_map_addr.push_back(ma);
            exp_map_addr.push_back(ma + idx_t'(1));
            for (int g = 0; g < j_ng; g++) begin
                // Unsigned lanes make a zero start neutral
                mx = '0;
                for (int j = 0; j < j_k; j++) begin
                    fa = j_rd + slot[j] * idx_t'(j_ng) + idx_t'(g);
                    exp_rd_addr.push_back(fa);
                    f = feat_mem[fa];
                    for (int i = 0; i < `POOL_LANES; i++) begin
                        if (f[i*`POOL_ACT_W +: `POOL_ACT_W] > mx[i*`POOL_ACT_W +: `POOL_ACT_W]) begin
                            mx[i*`POOL_ACT_W +: `POOL_ACT_W] = f[i*`POOL_ACT_W +: `POOL_ACT_W];
                        end
                    end
                end
                exp_wr_addr.push_back(j_wr + idx_t'(p * j_ng + g));
                exp_wr_dat.push_back(mx);
            end
        end
    endfunction

    // ==============================
    // Memory models and monitors
    // ==============================
    // Handshakes sampled mid-cycle where DUT outputs have settled
    always @(negedge clk) begin
        idx_t ea;
        if (map_rd_addr_vld && map_rd_addr_rdy) begin
            check_cond(exp_map_addr.size() > 0, "map read issued beyond the end of the job");
            if (exp_map_addr.size() > 0) begin
                ea = exp_map_addr.pop_front();
                check_val("map_rd_addr", 64'(ea), 64'(map_rd_addr));
            end
            map_pend.push_back(map_mem[map_rd_addr]);
        end
        if (map_rd_dat_vld && map_rd_dat_rdy) begin
            void'(map_pend.pop_front());
            map_taken = 1'b1;
        end
        if (ofm_rd_addr_vld && ofm_rd_addr_rdy) begin
            check_cond(exp_rd_addr.size() > 0, "feature read issued beyond the end of the job");
            if (exp_rd_addr.size() > 0) begin
                ea = exp_rd_addr.pop_front();
                check_val("ofm_rd_addr", 64'(ea), 64'(ofm_rd_addr));
            end
            feat_pend.push_back(feat_mem[ofm_rd_addr]);
        end
        // A pending result holds off further feature returns
        if (ofm_wr_vld) begin
            check_val("ofm_rd_dat_rdy with result pending", 64'd0, 64'(ofm_rd_dat_rdy));
        end
        if (ofm_rd_dat_vld && ofm_rd_dat_rdy) begin
            void'(feat_pend.pop_front());
            feat_taken = 1'b1;
        end
        if (ofm_wr_vld && ofm_wr_rdy) begin
            wr_cnt++;
            check_cond(exp_wr_addr.size() > 0, "result written beyond the end of the job");
            if (exp_wr_addr.size() > 0) begin
                check_val("ofm_wr_addr", 64'(exp_wr_addr.pop_front()), 64'(ofm_wr_addr));
                check_val("ofm_wr_dat", 64'(exp_wr_dat.pop_front()), 64'(ofm_wr_dat));
            end
        end
    end

    // Random readies and data valids held until taken
    always @(posedge clk) begin
        #1;
        map_rd_addr_rdy = (rand_bits(2) != 0);
        ofm_rd_addr_rdy = (rand_bits(2) != 0);
        ofm_wr_rdy      = (rand_bits(2) != 0);
        if (map_taken || !map_rd_dat_vld) begin
            map_rd_dat_vld = (map_pend.size() > 0) && (rand_bits(1) != 0);
            map_rd_dat     = (map_pend.size() > 0) ? map_pend[0] : '0;
        end
        if (feat_taken || !ofm_rd_dat_vld) begin
            ofm_rd_dat_vld = (feat_pend.size() > 0) && (rand_bits(1) != 0);
            ofm_rd_dat     = (feat_pend.size() > 0) ? feat_pend[0] : '0;
        end
        map_taken  = 1'b0;
        feat_taken = 1'b0;
    end

    // ==============================
    // Job sequence
    // ==============================
    task automatic run_job();
        int wait_cnt;
        int wr_start;
        build_job();
        wr_start = wr_cnt;
        @(posedge clk);
        #1;
        cfg_vld         = 1'b1;
        cfg_nip         = idx_t'(j_nip);
        cfg_k           = k_cnt_t'(j_k);
        cfg_n_grp       = grp_cnt_t'(j_ng);
        cfg_map_base    = j_map;
        cfg_ofm_rd_base = j_rd;
        cfg_ofm_wr_base = j_wr;
        wait_cnt = 0;
        @(negedge clk);
        while (!cfg_rdy && wait_cnt < WAIT_MAX) begin
            @(negedge clk);
            wait_cnt++;
        end
        check_cond(cfg_rdy, "configuration handshake timed out");
        @(posedge clk);
        #1;
        cfg_vld = 1'b0;
        // Job ends when cfg_rdy comes back
        wait_cnt = 0;
        @(negedge clk);
        while (!cfg_rdy && wait_cnt < WAIT_MAX) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!cfg_rdy) begin
            check_cond(1'b0, "job did not finish before the timeout");
            timed_out = 1'b1;
        end else begin
            check_val("write count", 64'(j_nip * j_ng), 64'(wr_cnt - wr_start));
            check_cond(exp_map_addr.size() == 0, "map reads missing at end of job");
            check_cond(exp_rd_addr.size() == 0, "feature reads missing at end of job");
            check_cond(exp_wr_addr.size() == 0, "result writes missing at end of job");
            check_cond(map_pend.size() == 0 && feat_pend.size() == 0,
                       "memory returns left unconsumed at end of job");
        end
    endtask

    initial begin
        lfsr       = 16'd53;
        err_cnt    = 0;
        chk_cnt    = 0;
        wr_cnt     = 0;
        timed_out  = 1'b0;
        map_taken  = 1'b0;
        feat_taken = 1'b0;
        rst_n           = 1'b1;
        cfg_vld         = 1'b0;
        cfg_nip         = '0;
        cfg_k           = '0;
        cfg_n_grp       = '0;
        cfg_map_base    = '0;
        cfg_ofm_rd_base = '0;
        cfg_ofm_wr_base = '0;
        map_rd_addr_rdy = 1'b0;
        map_rd_dat_vld  = 1'b0;
        map_rd_dat      = '0;
        ofm_rd_addr_rdy = 1'b0;
        ofm_rd_dat_vld  = 1'b0;
        ofm_rd_dat      = '0;
        ofm_wr_rdy      = 1'b0;
        #1 rst_n = 1'b0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_idle("in reset");
        @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        for (int n = 0; n < NUM_JOBS && !timed_out; n++) begin
            run_job();
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", chk_cnt, err_cnt, int'(timed_out));
        if (err_cnt == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/map_fetch.sv */
// Map read channel: per-point address generation and
// serial-to-parallel assembly of map words into a neighbor map
`include "pool_macros.svh"

module map_fetch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 running,
    cfg_if.cfg_snk               cfg,
    output pool_pkg::idx_t       map_rd_addr,
    output logic                 map_rd_addr_vld,
    input  logic                 map_rd_addr_rdy,
    input  logic                 map_rd_dat_vld,
    input  pool_pkg::sram_word_t map_rd_dat,
    output logic                 map_rd_dat_rdy,
    nbr_if.nbr_src               nbr
);
    import pool_pkg::*;

    localparam int WORD_W = $clog2(`POOL_MAP_WORDS);

    idx_t              pt_cnt;
    logic [WORD_W-1:0] addr_word;
    logic [WORD_W-1:0] dat_word;
    logic              addr_done;
    logic              map_full;
    nbr_map_t          map_buf;
    logic              addr_hs;
    logic              dat_hs;
    logic              nbr_hs;
    logic              last_pt;

    assign addr_hs = map_rd_addr_vld && map_rd_addr_rdy;
    assign dat_hs  = map_rd_dat_vld && map_rd_dat_rdy;
    assign nbr_hs  = nbr.vld && nbr.rdy;
    assign last_pt = (pt_cnt == cfg.nip - idx_t'(1));

    assign map_rd_addr_vld = running && !addr_done;
    assign map_rd_addr     = cfg.map_base + pt_cnt * idx_t'(`POOL_MAP_WORDS) + idx_t'(addr_word);
    // Buffer holds one map; stall returns until it is handed over
    assign map_rd_dat_rdy  = running && !map_full;

    assign nbr.vld   = map_full;
    assign nbr.map   = map_buf;
    assign nbr.point = pt_cnt;

    // ==============================
    // Address side
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pt_cnt    <= '0;
            addr_word <= '0;
            addr_done <= 1'b0;
        end else if (!running) begin
            pt_cnt    <= '0;
            addr_word <= '0;
            addr_done <= 1'b0;
        end else begin
            if (addr_hs) begin
                if (addr_word == WORD_W'(`POOL_MAP_WORDS - 1)) begin
                    addr_word <= '0;
                    addr_done <= 1'b1;
                end else begin
                    addr_word <= addr_word + 1'b1;
                end
            end
            // Next point starts once the previous map has left
            if (nbr_hs && !last_pt) begin
                pt_cnt    <= pt_cnt + idx_t'(1);
                addr_done <= 1'b0;
            end
        end
    end

    // ==============================
    // Data side
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dat_word <= '0;
            map_full <= 1'b0;
        end else if (!running) begin
            dat_word <= '0;
            map_full <= 1'b0;
        end else if (dat_hs) begin
            if (dat_word == WORD_W'(`POOL_MAP_WORDS - 1)) begin
                dat_word <= '0;
                map_full <= 1'b1;
            end else begin
                dat_word <= dat_word + 1'b1;
            end
        end else if (nbr_hs) begin
            map_full <= 1'b0;
        end
    end

    // Word 0 shifts down into the low slots
    always_ff @(posedge clk) begin
        if (dat_hs) begin
            map_buf <= {map_rd_dat, map_buf[$bits(nbr_map_t)-1:`POOL_SRAM_W]};
        end
    end

endmodule

/* verilog/max_reduce.sv */
// Lane-wise max over K feature returns, result write channel
// and end-of-job detection
`include "pool_macros.svh"

module max_reduce (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                running,
    cfg_if.cfg_snk              cfg,
    input  logic                ofm_rd_dat_vld,
    input  pool_pkg::lane_vec_t ofm_rd_dat,
    output logic                ofm_rd_dat_rdy,
    output pool_pkg::idx_t      ofm_wr_addr,
    output pool_pkg::lane_vec_t ofm_wr_dat,
    output logic                ofm_wr_vld,
    input  logic                ofm_wr_rdy,
    output logic                job_done
);
    import pool_pkg::*;

    k_cnt_t    ret_cnt;
    grp_cnt_t  g_cnt;
    idx_t      p_cnt;
    lane_vec_t lane_max;
    lane_vec_t lane_nxt;
    logic      rd_hs;
    logic      wr_hs;
    logic      g_last;
    logic      p_last;

    assign rd_hs  = ofm_rd_dat_vld && ofm_rd_dat_rdy;
    assign wr_hs  = ofm_wr_vld && ofm_wr_rdy;
    assign g_last = (g_cnt == cfg.n_grp - grp_cnt_t'(1));
    assign p_last = (p_cnt == cfg.nip - idx_t'(1));

    // Returns wait while a result is pending
    assign ofm_rd_dat_rdy = running && !ofm_wr_vld;
    assign ofm_wr_dat     = lane_max;
    assign ofm_wr_addr    = cfg.ofm_wr_base + p_cnt * idx_t'(cfg.n_grp) + idx_t'(g_cnt);
    assign job_done       = wr_hs && g_last && p_last;

    // ==============================
    // Compare lanes
    // ==============================
    always_comb begin
        act_t new_a;
        act_t old_a;
        for (int i = 0; i < `POOL_LANES; i++) begin
            new_a = ofm_rd_dat[i*`POOL_ACT_W +: `POOL_ACT_W];
            old_a = lane_max[i*`POOL_ACT_W +: `POOL_ACT_W];
            // First return of a group just loads
            lane_nxt[i*`POOL_ACT_W +: `POOL_ACT_W] =
                (ret_cnt == '0 || new_a > old_a) ? new_a : old_a;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            lane_max <= lane_nxt;
        end
    end

    // Return count, result valid, point and group position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_cnt    <= '0;
            g_cnt      <= '0;
            p_cnt      <= '0;
            ofm_wr_vld <= 1'b0;
        end else if (!running) begin
            ret_cnt    <= '0;
            g_cnt      <= '0;
            p_cnt      <= '0;
            ofm_wr_vld <= 1'b0;
        end else if (rd_hs) begin
            if (ret_cnt == cfg.k - k_cnt_t'(1)) begin
                ret_cnt    <= '0;
                ofm_wr_vld <= 1'b1;
            end else begin
                ret_cnt <= ret_cnt + k_cnt_t'(1);
            end
        end else if (wr_hs) begin
            ofm_wr_vld <= 1'b0;
            if (g_last) begin
                g_cnt <= '0;
                p_cnt <= p_cnt + idx_t'(1);
            end else begin
                g_cnt <= g_cnt + grp_cnt_t'(1);
            end
        end
    end

endmodule

/* verilog/nbr_gather.sv */
// Feature read address issue: group-outer, neighbor-inner loops
// over one held neighbor map
`include "pool_macros.svh"

module nbr_gather (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           running,
    cfg_if.cfg_snk         cfg,
    nbr_if.nbr_snk         nbr,
    output pool_pkg::idx_t ofm_rd_addr,
    output logic           ofm_rd_addr_vld,
    input  logic           ofm_rd_addr_rdy
);
    import pool_pkg::*;

    nbr_map_t map_r;
    logic     held;
    logic     pt_last;
    logic     all_issued;
    k_cnt_t   j_cnt;
    grp_cnt_t g_cnt;
    idx_t     slot_idx;
    logic     addr_hs;
    logic     j_last;
    logic     g_last;
    logic     map_end;
    logic     nbr_hs;

    assign addr_hs = ofm_rd_addr_vld && ofm_rd_addr_rdy;
    assign j_last  = (j_cnt == cfg.k - k_cnt_t'(1));
    assign g_last  = (g_cnt == cfg.n_grp - grp_cnt_t'(1));
    assign map_end = addr_hs && j_last && g_last;

    // Take a new map when empty or as the last address goes out
    assign nbr.rdy = running && !all_issued && (!held || map_end);
    assign nbr_hs  = nbr.vld && nbr.rdy;

    assign slot_idx        = map_r[j_cnt*`POOL_IDX_W +: `POOL_IDX_W];
    assign ofm_rd_addr     = cfg.ofm_rd_base + slot_idx * idx_t'(cfg.n_grp) + idx_t'(g_cnt);
    assign ofm_rd_addr_vld = running && held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held       <= 1'b0;
            pt_last    <= 1'b0;
            all_issued <= 1'b0;
            j_cnt      <= '0;
            g_cnt      <= '0;
        end else if (!running) begin
            held       <= 1'b0;
            pt_last    <= 1'b0;
            all_issued <= 1'b0;
            j_cnt      <= '0;
            g_cnt      <= '0;
        end else if (nbr_hs) begin
            held    <= 1'b1;
            pt_last <= (nbr.point == cfg.nip - idx_t'(1));
            j_cnt   <= '0;
            g_cnt   <= '0;
        end else if (map_end) begin
            held       <= 1'b0;
            all_issued <= pt_last;
        end else if (addr_hs) begin
            if (j_last) begin
                j_cnt <= '0;
                g_cnt <= g_cnt + grp_cnt_t'(1);
            end else begin
                j_cnt <= j_cnt + k_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (nbr_hs) begin
            map_r <= nbr.map;
        end
    end

endmodule

/* verilog/pool_ctrl.sv */
// Configuration capture and the job control FSM

module pool_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_vld,
    output logic               cfg_rdy,
    input  pool_pkg::idx_t     cfg_nip,
    input  pool_pkg::k_cnt_t   cfg_k,
    input  pool_pkg::grp_cnt_t cfg_n_grp,
    input  pool_pkg::idx_t     cfg_map_base,
    input  pool_pkg::idx_t     cfg_ofm_rd_base,
    input  pool_pkg::idx_t     cfg_ofm_wr_base,
    input  logic               job_done,
    output logic               running,
    cfg_if.cfg_src             cfg
);
    import pool_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        cfg_hs;

    assign cfg_rdy = (state == IDLE);
    assign running = (state == RUN);
    assign cfg_hs  = cfg_vld && cfg_rdy;

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (cfg_hs) state_nxt = RUN;
            RUN:     if (job_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Job parameters, held until the next handshake
    always_ff @(posedge clk) begin
        if (cfg_hs) begin
            cfg.nip         <= cfg_nip;
            cfg.k           <= cfg_k;
            cfg.n_grp       <= cfg_n_grp;
            cfg.map_base    <= cfg_map_base;
            cfg.ofm_rd_base <= cfg_ofm_rd_base;
            cfg.ofm_wr_base <= cfg_ofm_wr_base;
        end
    end

endmodule

/* verilog/pool_if.sv */
// Job configuration interface and neighbor-map handover interface

interface cfg_if;
    import pool_pkg::*;

    idx_t     nip;
    k_cnt_t   k;
    grp_cnt_t n_grp;
    idx_t     map_base;
    idx_t     ofm_rd_base;
    idx_t     ofm_wr_base;

    modport cfg_src (output nip, k, n_grp, map_base, ofm_rd_base, ofm_wr_base);
    modport cfg_snk (input  nip, k, n_grp, map_base, ofm_rd_base, ofm_wr_base);
endinterface

interface nbr_if;
    import pool_pkg::*;

    logic     vld;
    logic     rdy;
    nbr_map_t map;
    idx_t     point;

    modport nbr_src (output vld, map, point, input  rdy);
    modport nbr_snk (input  vld, map, point, output rdy);
endinterface

/* verilog/pool_macros.svh */
// Widths and counts shared across the neighbor max-pooling design
`ifndef POOL_MACROS_SVH
`define POOL_MACROS_SVH

// Addresses and point indices
`define POOL_IDX_W      16

// One activation and the lanes packed into a feature word
`define POOL_ACT_W      8
`define POOL_LANES      4

// Neighbor slots per map and the width of a map memory word
`define POOL_MAP_SLOTS  8
`define POOL_SRAM_W     64

// Map words needed to carry one full neighbor map
`define POOL_MAP_WORDS  ((`POOL_MAP_SLOTS * `POOL_IDX_W) / `POOL_SRAM_W)

// Neighbor count, 1 to 8
`define POOL_K_W        4

// Channel-group count
`define POOL_GRP_W      4

`endif

/* verilog/pool_pkg.sv */
// Vector typedefs and the control state enum
`include "pool_macros.svh"

package pool_pkg;

    // ==============================
    // Data widths
    // ==============================
    typedef logic [`POOL_IDX_W-1:0] idx_t;
    typedef logic [`POOL_ACT_W-1:0] act_t;

    // Lane 0 sits in the low bits
    typedef logic [`POOL_LANES*`POOL_ACT_W-1:0] lane_vec_t;

    typedef logic [`POOL_SRAM_W-1:0] sram_word_t;

    // Slot 0 in the low bits, one index per slot
    typedef logic [`POOL_MAP_SLOTS*`POOL_IDX_W-1:0] nbr_map_t;

    // ==============================
    // Loop counters
    // ==============================
    typedef logic [`POOL_K_W-1:0]   k_cnt_t;
    typedef logic [`POOL_GRP_W-1:0] grp_cnt_t;

    // Job control FSM
    typedef enum logic {
        IDLE,
        RUN
    } ctrl_state_t;

endpackage

/* verilog/pool_top.sv */
// Pooling core top level: control, map fetch, gather and reduce

module pool_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // Configuration
    input  logic                 cfg_vld,
    output logic                 cfg_rdy,
    input  pool_pkg::idx_t       cfg_nip,
    input  pool_pkg::k_cnt_t     cfg_k,
    input  pool_pkg::grp_cnt_t   cfg_n_grp,
    input  pool_pkg::idx_t       cfg_map_base,
    input  pool_pkg::idx_t       cfg_ofm_rd_base,
    input  pool_pkg::idx_t       cfg_ofm_wr_base,
    // Map read
    output pool_pkg::idx_t       map_rd_addr,
    output logic                 map_rd_addr_vld,
    input  logic                 map_rd_addr_rdy,
    input  logic                 map_rd_dat_vld,
    input  pool_pkg::sram_word_t map_rd_dat,
    output logic                 map_rd_dat_rdy,
    // Feature read
    output pool_pkg::idx_t       ofm_rd_addr,
    output logic                 ofm_rd_addr_vld,
    input  logic                 ofm_rd_addr_rdy,
    input  logic                 ofm_rd_dat_vld,
    input  pool_pkg::lane_vec_t  ofm_rd_dat,
    output logic                 ofm_rd_dat_rdy,
    // Result write
    output pool_pkg::idx_t       ofm_wr_addr,
    output pool_pkg::lane_vec_t  ofm_wr_dat,
    output logic                 ofm_wr_vld,
    input  logic                 ofm_wr_rdy
);

    logic running;
    logic job_done;

    cfg_if u_cfg ();
    nbr_if u_nbr ();

    pool_ctrl u_ctrl (
        .clk, .rst_n, .cfg_vld, .cfg_rdy, .cfg_nip, .cfg_k, .cfg_n_grp,
        .cfg_map_base, .cfg_ofm_rd_base, .cfg_ofm_wr_base,
        .job_done, .running, .cfg (u_cfg.cfg_src)
    );

    map_fetch u_map (
        .clk, .rst_n, .running, .cfg (u_cfg.cfg_snk),
        .map_rd_addr, .map_rd_addr_vld, .map_rd_addr_rdy,
        .map_rd_dat_vld, .map_rd_dat, .map_rd_dat_rdy, .nbr (u_nbr.nbr_src)
    );

    nbr_gather u_gather (
        .clk, .rst_n, .running, .cfg (u_cfg.cfg_snk), .nbr (u_nbr.nbr_snk),
        .ofm_rd_addr, .ofm_rd_addr_vld, .ofm_rd_addr_rdy
    );

    max_reduce u_reduce (
        .clk, .rst_n, .running, .cfg (u_cfg.cfg_snk),
        .ofm_rd_dat_vld, .ofm_rd_dat, .ofm_rd_dat_rdy,
        .ofm_wr_addr, .ofm_wr_dat, .ofm_wr_vld, .ofm_wr_rdy, .job_done
    );

endmodule
